//--- Makefile
VERILATOR ?= verilator
TOP       ?= robTb
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f filelist.f
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- bench/robTb.sv
`timescale 1ns/1ps

module robTb;
  import robPkg::*;

  logic                    clock;
  logic                    reset;
  dispatchPacket_t         dispatch;
  completePacket_t         complete;
  rollback_t               rollback;
  logic [archIdxWidth-1:0] archReadIdx;
  logic [creditWidth-1:0]  creditReturn;
  logic                    dispatchBlocked;
  retirePacket_t           retire;
  logic                    halted;
  logic [physTagWidth-1:0] archReadTag;

  // reference model, indexed by ROB slot, order holds slots oldest first
  int mDest [robDepth];
  int mNew [robDepth];
  int mOld [robDepth];
  bit mHalt [robDepth];
  bit mDone [robDepth];
  int order [$];
  int mHead;
  int mTail;
  int mState;
  int mBranch;
  int expCredit;
  int credits;
  int cycles;
  int cycleLimit;
  bit checkArch;
  int checkTag;

  reorderBuffer dut_i (
    .clock           (clock),
    .reset           (reset),
    .dispatch        (dispatch),
    .complete        (complete),
    .rollback        (rollback),
    .archReadIdx     (archReadIdx),
    .creditReturn    (creditReturn),
    .dispatchBlocked (dispatchBlocked),
    .retire          (retire),
    .halted          (halted),
    .archReadTag     (archReadTag)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycleLimit) begin
      failRun("timeout: the DUT stopped making progress");
    end
  end

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input int got, input int exp, input string what);
    assert (got == exp) else
      failRun($sformatf("error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic checkLane(input int lane, input int slot);
    checkValue(retire[lane].halt, mHalt[slot], $sformatf("lane %0d halt", lane));
    checkValue(retire[lane].destArch, mDest[slot], $sformatf("lane %0d destArch", lane));
    checkValue(retire[lane].newTag, mNew[slot], $sformatf("lane %0d newTag", lane));
    checkValue(retire[lane].oldTag, mOld[slot], $sformatf("lane %0d oldTag", lane));
  endtask

  function automatic int findOrder(input int slot);
    for (int i = 0; i < order.size(); i++) begin
      if (order[i] == slot) return i;
    end
    return -1;
  endfunction

  task automatic clearInputs();
    dispatch    = '0;
    complete    = '0;
    rollback    = '0;
    archReadIdx = '0;
  endtask

  // check the cycle at the falling edge, then advance the model
  task automatic stepCycle();
    bit accept;
    bit p0;
    bit p1;
    bit haltRet;
    int pos;
    int flushed;
    int nextState;
    int slot;
    @(negedge clock);
    accept = rollback.valid && (mState == 0) && (findOrder(rollback.branchIdx) >= 0);
    p0 = (mState != 2) && (order.size() > 0);
    if (p0) p0 = mDone[order[0]];
    p1 = p0 && !mHalt[order[0]] && (order.size() > 1);
    if (p1) p1 = mDone[order[1]] && !(accept && (rollback.branchIdx == order[0]));
    checkValue(retire[0].valid, p0, "lane 0 valid");
    if (p0) checkLane(0, order[0]);
    checkValue(retire[1].valid, p1, "lane 1 valid");
    if (p1) checkLane(1, order[1]);
    checkValue(creditReturn, expCredit, "creditReturn");
    credits += creditReturn;
    checkValue(dispatchBlocked, mState == 1, "dispatchBlocked");
    checkValue(halted, mState == 2, "halted");
    if (checkArch) checkValue(archReadTag, checkTag, "archReadTag");

    haltRet = (p0 && mHalt[order[0]]) || (p1 && mHalt[order[1]]);
    nextState = mState;
    if (mState == 0) begin
      if (haltRet) nextState = 2;
      else if (accept) nextState = 1;
    end else if (mState == 1) begin
      if (haltRet) nextState = 2;
      else if (mHead == mBranch || mHead == (mBranch + 1) % robDepth) nextState = 0;
    end

    flushed = 0;
    if (accept) begin
      pos = findOrder(rollback.branchIdx);
      // entries younger than the branch, plus lanes dropped on this edge
      flushed = order.size() - (pos + 1);
      flushed += dispatch[0].valid + dispatch[1].valid;
      while (order.size() > pos + 1) void'(order.pop_back());
      mTail = (rollback.branchIdx + 1) % robDepth;
      mBranch = rollback.branchIdx;
    end
    repeat (int'(p0) + int'(p1)) void'(order.pop_front());
    mHead = (mHead + p0 + p1) % robDepth;

    if (!accept) begin
      for (int i = 0; i < superWidth; i++) begin
        if (dispatch[i].valid) begin
          slot = mTail;
          mHalt[slot] = dispatch[i].halt;
          mDest[slot] = dispatch[i].destArch;
          mNew[slot] = dispatch[i].newTag;
          mOld[slot] = dispatch[i].oldTag;
          mDone[slot] = 1'b0;
          order.push_back(slot);
          mTail = (mTail + 1) % robDepth;
        end
      end
    end
    for (int i = 0; i < superWidth; i++) begin
      if (complete[i].valid) mDone[complete[i].robIdx] = 1'b1;
    end
    expCredit = p0 + p1 + flushed;
    mState = nextState;
    @(posedge clock);
    #2;
  endtask

  initial begin
    int fd;
    int code;
    int v [9];
    bit done;
    string cmd;
    string line;
    reset = 1'b1;
    clearInputs();
    cycles = 0;
    cycleLimit = 100;
    mHead = 0;
    mTail = 0;
    mState = 0;
    mBranch = 0;
    expCredit = 0;
    credits = robDepth;
    checkArch = 1'b0;
    checkTag = 0;
    for (int i = 0; i < robDepth; i++) mDone[i] = 1'b0;
    fd = $fopen("bench/robTests.dat", "r");
    if (fd == 0) failRun("could not open bench/robTests.dat");
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) failRun("the test file ended without an end command");
      cycleLimit += 20;
      clearInputs();
      case (cmd)
        "#": code = $fgets(line, fd);
        "D": begin
          code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d",
                         v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
          if (code != 9) failRun("a dispatch line is malformed");
          // the dispatcher waits for credit and for the block to lift
          while (credits < v[0] || dispatchBlocked) stepCycle();
          for (int i = 0; i < v[0]; i++) begin
            dispatch[i].valid = 1'b1;
            dispatch[i].halt = v[1 + 4 * i];
            dispatch[i].destArch = v[2 + 4 * i];
            dispatch[i].newTag = v[3 + 4 * i];
            dispatch[i].oldTag = v[4 + 4 * i];
          end
          credits -= v[0];
          stepCycle();
        end
        "C": begin
          code = $fscanf(fd, "%d %d %d", v[0], v[1], v[2]);
          if (code != 3) failRun("a complete line is malformed");
          for (int i = 0; i < v[0]; i++) begin
            complete[i].valid = 1'b1;
            complete[i].robIdx = v[1 + i];
          end
          stepCycle();
        end
        "R": begin
          code = $fscanf(fd, "%d", v[0]);
          if (code != 1) failRun("a rollback line is malformed");
          rollback.valid = 1'b1;
          rollback.branchIdx = v[0];
          stepCycle();
        end
        "I": begin
          code = $fscanf(fd, "%d", v[0]);
          if (code != 1) failRun("an idle line is malformed");
          repeat (v[0]) stepCycle();
        end
        "K": begin
          code = $fscanf(fd, "%d %d", v[0], v[1]);
          if (code != 2) failRun("a check line is malformed");
          archReadIdx = v[0];
          checkTag = v[1];
          checkArch = 1'b1;
          stepCycle();
          checkArch = 1'b0;
        end
        "S": begin
          code = $fscanf(fd, "%d", v[0]);
          if (code != 1) failRun("a credit line is malformed");
          checkValue(credits, v[0], "credit count");
        end
        "E": done = 1'b1;
        default: failRun($sformatf("unknown command %s in the test file", cmd));
      endcase
    end
    $fclose(fd);
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- bench/robTests.dat
# D count halt0 dest0 new0 old0 halt1 dest1 new1 old1 | C count idx0 idx1 | R branchIdx
# I cycles | K archReg expectedTag | S expectedCredits | E
K 0 0
K 5 5
K 31 31
# eight instructions, completed out of order
D 2 0 1 32 1 0 2 33 2
D 2 0 3 34 3 0 4 35 4
D 2 0 1 36 32 0 5 37 5
D 2 0 6 38 6 0 2 39 33
C 2 5 3
C 2 7 1
C 1 0 0
C 2 2 6
C 1 4 0
I 4
S 16
K 1 36
K 2 39
K 3 34
K 4 35
K 5 37
K 6 38
# fill all sixteen entries
D 2 0 10 40 10 0 11 41 11
D 2 0 12 42 12 0 13 43 13
D 2 0 14 44 14 0 15 45 15
D 2 0 16 46 16 0 17 47 17
D 2 0 18 48 18 0 19 49 19
D 2 0 20 50 20 0 21 51 21
D 2 0 22 52 22 0 23 53 23
D 2 0 24 54 24 0 25 55 25
S 0
C 2 15 14
C 2 8 9
C 2 10 11
C 2 12 13
C 2 0 1
C 2 2 3
C 2 4 5
C 2 6 7
I 10
S 16
K 25 55
K 10 40
# ten instructions, rollback at the fourth
D 2 0 1 56 36 0 2 57 39
D 2 0 3 58 34 0 4 59 35
D 2 0 5 60 37 0 6 61 38
D 2 0 7 62 7 0 8 63 8
D 2 0 9 30 9 0 3 31 58
C 2 12 13
C 2 0 1
R 11
C 2 9 8
C 2 11 10
D 2 0 5 20 37 0 9 21 9
C 2 12 13
I 4
S 16
K 1 56
K 3 58
K 4 59
K 5 20
K 9 21
K 6 38
K 7 7
# halt in lane 1, the younger instruction must never retire
D 2 0 12 10 42 1 0 0 0
D 1 0 13 11 43 0 0 0 0
C 2 0 15
C 1 14 0
I 6
K 12 10
K 13 43
E

//--- filelist.f
rtl/robPkg.sv
rtl/robPointers.sv
rtl/robRecoveryFsm.sv
rtl/robEntries.sv
rtl/archMap.sv
rtl/reorderBuffer.sv
bench/robTb.sv

//--- rtl/archMap.sv
`timescale 1ns/1ps

module archMap (
  input  logic                              clock,
  input  logic                              reset,
  input  robPkg::retirePacket_t             retire,
  input  logic [robPkg::archIdxWidth-1:0]   archReadIdx,
  output logic [robPkg::physTagWidth-1:0]   archReadTag
);
  import robPkg::*;

  logic [physTagWidth-1:0] mapTable [archRegs];

  // committed mapping, no bypass of this cycle's retirement
  assign archReadTag = mapTable[archReadIdx];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity mapping out of reset
      for (int r = 0; r < archRegs; r++) begin
        mapTable[r] <= physTagWidth'(r);
      end
    end else begin
      // later lane is younger, so it overwrites lane 0 on a clash
      for (int i = 0; i < superWidth; i++) begin
        if (retire[i].valid) begin
          mapTable[retire[i].destArch] <= retire[i].newTag;
        end
      end
    end
  end

endmodule

//--- rtl/reorderBuffer.sv
`timescale 1ns/1ps

module reorderBuffer (
  input  logic                              clock,
  input  logic                              reset,
  input  robPkg::dispatchPacket_t           dispatch,
  input  robPkg::completePacket_t           complete,
  input  robPkg::rollback_t                 rollback,
  input  logic [robPkg::archIdxWidth-1:0]   archReadIdx,
  output logic [robPkg::creditWidth-1:0]    creditReturn,
  output logic                              dispatchBlocked,
  output robPkg::retirePacket_t             retire,
  output logic                              halted,
  output logic [robPkg::physTagWidth-1:0]   archReadTag
);
  import robPkg::*;

  logic [robIdxWidth-1:0] head;
  logic [robIdxWidth-1:0] tail;
  logic [1:0]             dispatchCount;
  logic [1:0]             retireCount;
  logic [1:0]             retireAllow;
  logic [1:0]             retireHalt;
  logic                   acceptRollback;
  logic                   branchValid;
  rollback_t              flushTail;

  assign flushTail.valid     = acceptRollback;
  assign flushTail.branchIdx = rollback.branchIdx;

  assign retireHalt[0] = retire[0].valid && retire[0].halt;
  assign retireHalt[1] = retire[1].valid && retire[1].halt;

  robPointers pointers (
    .clock         (clock),
    .reset         (reset),
    .dispatchCount (dispatchCount),
    .retireCount   (retireCount),
    .flushTail     (flushTail),
    .head          (head),
    .tail          (tail),
    .flushedCount  (),
    .creditReturn  (creditReturn)
  );

  robRecoveryFsm recovery (
    .clock           (clock),
    .reset           (reset),
    .rollback        (rollback),
    .branchValid     (branchValid),
    .head            (head),
    .retireHalt      (retireHalt),
    .acceptRollback  (acceptRollback),
    .dispatchBlocked (dispatchBlocked),
    .retireAllow     (retireAllow),
    .halted          (halted)
  );

  robEntries entries (
    .clock          (clock),
    .reset          (reset),
    .dispatch       (dispatch),
    .complete       (complete),
    .head           (head),
    .tail           (tail),
    .acceptRollback (acceptRollback),
    .branchIdx      (rollback.branchIdx),
    .retireAllow    (retireAllow),
    .branchValid    (branchValid),
    .dispatchCount  (dispatchCount),
    .retireCount    (retireCount),
    .retire         (retire)
  );

  archMap committedMap (
    .clock       (clock),
    .reset       (reset),
    .retire      (retire),
    .archReadIdx (archReadIdx),
    .archReadTag (archReadTag)
  );

endmodule

//--- rtl/robEntries.sv
`timescale 1ns/1ps

module robEntries (
  input  logic                              clock,
  input  logic                              reset,
  input  robPkg::dispatchPacket_t           dispatch,
  input  robPkg::completePacket_t           complete,
  input  logic [robPkg::robIdxWidth-1:0]    head,
  input  logic [robPkg::robIdxWidth-1:0]    tail,
  input  logic                              acceptRollback,
  input  logic [robPkg::robIdxWidth-1:0]    branchIdx,
  input  logic [1:0]                        retireAllow,
  output logic                              branchValid,
  output logic [1:0]                        dispatchCount,
  output logic [1:0]                        retireCount,
  output robPkg::retirePacket_t             retire
);
  import robPkg::*;

  logic [robDepth-1:0]    entryValid;
  logic [robDepth-1:0]    entryComplete;
  logic [robDepth-1:0]    validNext;
  logic [robDepth-1:0]    completeNext;
  dispatchLane_t          entryData [robDepth];
  logic [robIdxWidth-1:0] writeIdx [superWidth];
  logic [robIdxWidth-1:0] readIdx [superWidth];
  logic [robIdxWidth-1:0] branchAge;

  assign branchValid = entryValid[branchIdx];
  assign branchAge   = branchIdx - head;

  // lane 1 is only ever valid together with lane 0
  assign dispatchCount = {1'b0, dispatch[0].valid} + {1'b0, dispatch[1].valid};
  assign retireCount   = {1'b0, retire[0].valid} + {1'b0, retire[1].valid};

  always_comb begin
    for (int i = 0; i < superWidth; i++) begin
      writeIdx[i] = tail + robIdxWidth'(i);
      readIdx[i]  = head + robIdxWidth'(i);
    end
  end

  // retire candidates come straight from registered state at the head
  always_comb begin
    for (int i = 0; i < superWidth; i++) begin
      retire[i].valid    = entryValid[readIdx[i]] && entryComplete[readIdx[i]]
                           && retireAllow[i];
      retire[i].halt     = entryData[readIdx[i]].halt;
      retire[i].destArch = entryData[readIdx[i]].destArch;
      retire[i].newTag   = entryData[readIdx[i]].newTag;
      retire[i].oldTag   = entryData[readIdx[i]].oldTag;
    end
    // in order only
    retire[1].valid = retire[1].valid && retire[0].valid;
    // branch at the head flushes the entry behind it
    if (acceptRollback && (branchAge == '0)) begin
      retire[1].valid = 1'b0;
    end
  end

  always_comb begin
    validNext    = entryValid;
    completeNext = entryComplete;

    // lanes arriving with a rollback are younger than the branch
    for (int i = 0; i < superWidth; i++) begin
      if (dispatch[i].valid && !acceptRollback) begin
        validNext[writeIdx[i]]    = 1'b1;
        completeNext[writeIdx[i]] = 1'b0;
      end
    end

    for (int i = 0; i < superWidth; i++) begin
      if (complete[i].valid) begin
        completeNext[complete[i].robIdx] = 1'b1;
      end
    end

    for (int i = 0; i < superWidth; i++) begin
      if (retire[i].valid) begin
        validNext[readIdx[i]] = 1'b0;
      end
    end

    // age relative to head takes care of wraparound
    if (acceptRollback) begin
      for (int k = 0; k < robDepth; k++) begin
        if (robIdxWidth'(k - int'(head)) > branchAge) begin
          validNext[k] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entryValid    <= '0;
      entryComplete <= '0;
    end else begin
      entryValid    <= validNext;
      entryComplete <= completeNext;
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < superWidth; i++) begin
      if (dispatch[i].valid && !acceptRollback) begin
        entryData[writeIdx[i]] <= dispatch[i];
      end
    end
  end

endmodule

//--- rtl/robPkg.sv
package robPkg;

  // machine width and ROB geometry
  localparam int superWidth   = 2;
  localparam int robDepth     = 16;
  localparam int robIdxWidth  = 4;
  localparam int archRegs     = 32;
  localparam int archIdxWidth = 5;
  localparam int physTagWidth = 6;
  // counts 0 through robDepth
  localparam int creditWidth  = 5;

  // one dispatched instruction
  typedef struct packed {
    logic                    valid;
    logic                    halt;
    logic [archIdxWidth-1:0] destArch;
    logic [physTagWidth-1:0] newTag;
    logic [physTagWidth-1:0] oldTag;
  } dispatchLane_t;

  // lane 0 is the oldest
  typedef dispatchLane_t [superWidth-1:0] dispatchPacket_t;

  typedef struct packed {
    logic                   valid;
    logic [robIdxWidth-1:0] robIdx;
  } completeLane_t;

  typedef completeLane_t [superWidth-1:0] completePacket_t;

  // mispredicted branch, everything younger gets flushed
  typedef struct packed {
    logic                   valid;
    logic [robIdxWidth-1:0] branchIdx;
  } rollback_t;

  // one committed instruction, oldTag goes back to the free list
  typedef struct packed {
    logic                    valid;
    logic                    halt;
    logic [archIdxWidth-1:0] destArch;
    logic [physTagWidth-1:0] newTag;
    logic [physTagWidth-1:0] oldTag;
  } retireLane_t;

  typedef retireLane_t [superWidth-1:0] retirePacket_t;

  typedef enum logic [1:0] {
    robRun,
    robRecover,
    robHalted
  } robState_t;

endpackage

//--- rtl/robPointers.sv
`timescale 1ns/1ps

module robPointers (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [1:0]                        dispatchCount,
  input  logic [1:0]                        retireCount,
  input  robPkg::rollback_t                 flushTail,
  output logic [robPkg::robIdxWidth-1:0]    head,
  output logic [robPkg::robIdxWidth-1:0]    tail,
  output logic [robPkg::creditWidth-1:0]    flushedCount,
  output logic [robPkg::creditWidth-1:0]    creditReturn
);
  import robPkg::*;

  logic [creditWidth-1:0] occupancy;
  logic [creditWidth-1:0] occupancyNext;
  logic [robIdxWidth-1:0] branchAge;
  logic [robIdxWidth-1:0] headNext;
  logic [robIdxWidth-1:0] tailNext;

  // entries older than the branch
  assign branchAge = flushTail.branchIdx - head;

  // everything from the branch up to the old tail goes away, plus any
  // lanes dispatched on the same edge as the rollback
  always_comb begin
    if (flushTail.valid) begin
      flushedCount = occupancy - creditWidth'(branchAge) - creditWidth'(1)
                     + creditWidth'(dispatchCount);
    end else begin
      flushedCount = '0;
    end
  end

  assign headNext = head + robIdxWidth'(retireCount);

  always_comb begin
    if (flushTail.valid) begin
      tailNext = flushTail.branchIdx + robIdxWidth'(1);
    end else begin
      tailNext = tail + robIdxWidth'(dispatchCount);
    end
  end

  assign occupancyNext = occupancy + creditWidth'(dispatchCount)
                         - creditWidth'(retireCount) - flushedCount;

  always_ff @(posedge clock) begin
    if (reset) begin
      head         <= '0;
      tail         <= '0;
      occupancy    <= '0;
      creditReturn <= '0;
    end else begin
      head         <= headNext;
      tail         <= tailNext;
      occupancy    <= occupancyNext;
      // one cycle pulse, the dispatcher adds it to its credits
      creditReturn <= creditWidth'(retireCount) + flushedCount;
    end
  end

endmodule

//--- rtl/robRecoveryFsm.sv
`timescale 1ns/1ps

module robRecoveryFsm (
  input  logic                              clock,
  input  logic                              reset,
  input  robPkg::rollback_t                 rollback,
  input  logic                              branchValid,
  input  logic [robPkg::robIdxWidth-1:0]    head,
  input  logic [1:0]                        retireHalt,
  output logic                              acceptRollback,
  output logic                              dispatchBlocked,
  output logic [1:0]                        retireAllow,
  output logic                              halted
);
  import robPkg::*;

  robState_t              state;
  robState_t              stateNext;
  logic [robIdxWidth-1:0] branchReg;
  logic                   headAtBranch;

  // only a live branch while running can start a recovery
  assign acceptRollback = rollback.valid && branchValid && (state == robRun);

  // retirement has drained down to the branch
  assign headAtBranch = (head == branchReg) || (head == branchReg + robIdxWidth'(1));

  always_comb begin
    stateNext = state;
    case (state)
      robRun: begin
        if (|retireHalt) begin
          stateNext = robHalted;
        end else if (acceptRollback) begin
          stateNext = robRecover;
        end
      end
      robRecover: begin
        // an older halt can still commit while recovering
        if (|retireHalt) begin
          stateNext = robHalted;
        end else if (headAtBranch) begin
          stateNext = robRun;
        end
      end
      default: stateNext = robHalted;
    endcase
  end

  assign dispatchBlocked = (state == robRecover);
  assign halted          = (state == robHalted);

  // lane 1 must not commit behind a halt in lane 0
  assign retireAllow[0] = (state != robHalted);
  assign retireAllow[1] = (state != robHalted) && !retireHalt[0];

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= robRun;
      branchReg <= '0;
    end else begin
      state <= stateNext;
      if (acceptRollback) begin
        branchReg <= rollback.branchIdx;
      end
    end
  end

endmodule
